/* common/video_pkg.sv */
`default_nettype none

package video_pkg;

    // horizontal timing in pixels, blanking follows active
    localparam int H_ACTIVE = 16;
    localparam int H_FRONT  = 2;
    localparam int H_SYNC   = 4;
    localparam int H_BACK   = 2;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

    // vertical timing in whole lines
    localparam int V_ACTIVE = 8;
    localparam int V_FRONT  = 1;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 1;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    // counter widths, sized for H_TOTAL and V_TOTAL
    localparam int X_W = 5;
    localparam int Y_W = 4;

    // TMDS control symbols, suffix is {vsync, hsync}
    localparam logic [9:0] CTRL_SYM_00 = 10'b1101010100;
    localparam logic [9:0] CTRL_SYM_01 = 10'b0010101011;
    localparam logic [9:0] CTRL_SYM_10 = 10'b0101010100;
    localparam logic [9:0] CTRL_SYM_11 = 10'b1010101011;

    // colour bars as {r, g, b}, left to right
    localparam logic [23:0] BAR_COLORS [0:7] = '{
        24'hFFFFFF,
        24'hFFFF00,
        24'h00FFFF,
        24'h00FF00,
        24'hFF00FF,
        24'hFF0000,
        24'h0000FF,
        24'h000000
    };

    // position and sync state of the current pixel
    typedef struct packed {
        logic [X_W-1:0] x;
        logic [Y_W-1:0] y;
        logic           hsync;
        logic           vsync;
        // high outside the active area
        logic           blank;
    } timing_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pixel_t;

    // one pixel clock worth of video for the encoders
    typedef struct packed {
        pixel_t pix;
        logic   hsync;
        logic   vsync;
        logic   blank;
    } video_beat_t;

endpackage

`default_nettype wire

/* source/video_timing.sv */
`timescale 1ns/1ps
`default_nettype none

module video_timing (
    input  logic               i_clk,
    input  logic               i_rst,
    output video_pkg::timing_t o_timing
);
    import video_pkg::*;

    localparam logic [X_W-1:0] X_LAST   = X_W'(H_TOTAL - 1);
    localparam logic [X_W-1:0] X_ACT    = X_W'(H_ACTIVE);
    localparam logic [X_W-1:0] HS_START = X_W'(H_ACTIVE + H_FRONT);
    localparam logic [X_W-1:0] HS_END   = X_W'(H_ACTIVE + H_FRONT + H_SYNC);

    localparam logic [Y_W-1:0] Y_LAST   = Y_W'(V_TOTAL - 1);
    localparam logic [Y_W-1:0] Y_ACT    = Y_W'(V_ACTIVE);
    localparam logic [Y_W-1:0] VS_START = Y_W'(V_ACTIVE + V_FRONT);
    localparam logic [Y_W-1:0] VS_END   = Y_W'(V_ACTIVE + V_FRONT + V_SYNC);

    // the counters live in the struct register itself
    timing_t        tim_q;
    timing_t        tim_next;
    logic [X_W-1:0] x_next;
    logic [Y_W-1:0] y_next;
    logic           line_end;

    always_comb begin
        line_end = (tim_q.x == X_LAST);

        if (line_end) begin
            x_next = '0;
        end else begin
            x_next = tim_q.x + 1'b1;
        end

        // line counter steps once per wrap of the pixel counter
        if (!line_end) begin
            y_next = tim_q.y;
        end else if (tim_q.y == Y_LAST) begin
            y_next = '0;
        end else begin
            y_next = tim_q.y + 1'b1;
        end

        // flags are decoded from the next position so they line up with it
        tim_next.x     = x_next;
        tim_next.y     = y_next;
        tim_next.blank = (x_next >= X_ACT) || (y_next >= Y_ACT);
        tim_next.hsync = (x_next >= HS_START) && (x_next < HS_END);
        tim_next.vsync = (y_next >= VS_START) && (y_next < VS_END);
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            // position 0,0 with all flags low
            tim_q <= '0;
        end else begin
            tim_q <= tim_next;
        end
    end

    assign o_timing = tim_q;

endmodule

`default_nettype wire

/* source/color_bar_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module color_bar_gen (
    input  logic                   i_clk,
    input  logic                   i_rst,
    input  video_pkg::timing_t     i_timing,
    output video_pkg::video_beat_t o_beat
);
    import video_pkg::*;

    // rows above this one show the bars, the rest the ramp
    localparam logic [Y_W-1:0] HALF_ROWS = Y_W'(V_ACTIVE / 2);

    pixel_t      pix_next;
    logic [2:0]  bar_idx;
    logic [7:0]  gray;
    video_beat_t beat_q;

    always_comb begin
        // bars are two pixels wide
        bar_idx = i_timing.x[3:1];
        // ramp steps by 16 per pixel across the active width
        gray = {i_timing.x[3:0], 4'h0};

        if (i_timing.blank) begin
            pix_next = '0;
        end else if (i_timing.y < HALF_ROWS) begin
            pix_next = BAR_COLORS[bar_idx];
        end else begin
            pix_next.r = gray;
            pix_next.g = gray;
            pix_next.b = gray;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            beat_q <= '0;
        end else begin
            beat_q.pix   <= pix_next;
            // sync and blank ride along in the same stage
            beat_q.hsync <= i_timing.hsync;
            beat_q.vsync <= i_timing.vsync;
            beat_q.blank <= i_timing.blank;
        end
    end

    assign o_beat = beat_q;

endmodule

`default_nettype wire

/* tmds/tmds_encoder.sv */
`timescale 1ns/1ps
`default_nettype none

module tmds_encoder (
    input  logic       i_clk,
    input  logic       i_rst,
    input  logic [7:0] i_data,
    // bit 0 is hsync, bit 1 is vsync
    input  logic [1:0] i_ctrl,
    input  logic       i_blank,
    output logic [9:0] o_symbol
);
    import video_pkg::*;

    logic [3:0]        ones_data;
    logic              use_xnor;
    logic [8:0]        q_m;
    logic [3:0]        ones_qm;
    logic signed [4:0] bal;
    logic signed [4:0] disp_ext;
    logic signed [4:0] qm8_ext;
    logic signed [4:0] disp_calc;
    logic [9:0]        sym_next;

    // running disparity, (ones - zeros) / 2
    logic signed [3:0] disp_q;
    logic [9:0]        sym_q;
    // low for the first clock after reset while the pattern stage fills
    logic              primed_q;

    always_comb begin
        ones_data = '0;
        for (int i = 0; i < 8; i++) begin
            ones_data = ones_data + {3'b000, i_data[i]};
        end

        use_xnor = (ones_data > 4'd4) || ((ones_data == 4'd4) && !i_data[0]);

        // transition minimised word, bit 8 high for XOR
        q_m[0] = i_data[0];
        for (int i = 1; i < 8; i++) begin
            q_m[i] = use_xnor ? ~(q_m[i-1] ^ i_data[i]) : (q_m[i-1] ^ i_data[i]);
        end
        q_m[8] = ~use_xnor;

        ones_qm = '0;
        for (int i = 0; i < 8; i++) begin
            ones_qm = ones_qm + {3'b000, q_m[i]};
        end

        // word imbalance in the same halved units as the disparity
        bal      = $signed({1'b0, ones_qm}) - 5'sd4;
        disp_ext = disp_q;
        qm8_ext  = $signed({4'b0000, q_m[8]});

        if (i_blank) begin
            case (i_ctrl)
                2'b00:   sym_next = CTRL_SYM_00;
                2'b01:   sym_next = CTRL_SYM_01;
                2'b10:   sym_next = CTRL_SYM_10;
                default: sym_next = CTRL_SYM_11;
            endcase
            disp_calc = '0;
        end else if ((disp_q == 4'sd0) || (bal == 5'sd0)) begin
            // balanced case, bit 8 alone picks the polarity
            sym_next = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
            if (q_m[8]) begin
                disp_calc = disp_ext + bal;
            end else begin
                disp_calc = disp_ext - bal;
            end
        end else if (disp_ext[4] == bal[4]) begin
            // word leans the same way as the line, invert it
            sym_next  = {1'b1, q_m[8], ~q_m[7:0]};
            disp_calc = disp_ext + qm8_ext - bal;
        end else begin
            sym_next  = {1'b0, q_m[8], q_m[7:0]};
            disp_calc = disp_ext - (5'sd1 - qm8_ext) + bal;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            sym_q    <= '0;
            disp_q   <= '0;
            primed_q <= 1'b0;
        end else begin
            primed_q <= 1'b1;
            if (primed_q) begin
                sym_q  <= sym_next;
                disp_q <= disp_calc[3:0];
            end
        end
    end

    assign o_symbol = sym_q;

endmodule

`default_nettype wire

/* source/dvi_tx_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dvi_tx_top (
    input  logic       i_clk,
    input  logic       i_rst,
    // blue, carries the syncs
    output logic [9:0] o_tmds_ch0,
    // green
    output logic [9:0] o_tmds_ch1,
    // red
    output logic [9:0] o_tmds_ch2
);
    import video_pkg::*;

    timing_t     timing;
    video_beat_t beat;
    pixel_t      pix;
    logic [1:0]  sync_ctrl;

    assign pix       = beat.pix;
    assign sync_ctrl = {beat.vsync, beat.hsync};

    video_timing u_timing (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .o_timing (timing)
    );

    color_bar_gen u_pattern (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_timing (timing),
        .o_beat   (beat)
    );

    tmds_encoder u_enc_b (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_data   (pix.b),
        .i_ctrl   (sync_ctrl),
        .i_blank  (beat.blank),
        .o_symbol (o_tmds_ch0)
    );

    // green and red send control 00 in blanking
    tmds_encoder u_enc_g (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_data   (pix.g),
        .i_ctrl   (2'b00),
        .i_blank  (beat.blank),
        .o_symbol (o_tmds_ch1)
    );

    tmds_encoder u_enc_r (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_data   (pix.r),
        .i_ctrl   (2'b00),
        .i_blank  (beat.blank),
        .o_symbol (o_tmds_ch2)
    );

endmodule

`default_nettype wire

/* sim/dvi_tx_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module dvi_tx_sva (
    input logic               i_clk,
    input logic               i_rst,
    input video_pkg::timing_t i_timing
);
    import video_pkg::*;

    // pixel counter wraps before the line total
    property x_in_range;
        @(posedge i_clk) disable iff (i_rst)
        int'(i_timing.x) < H_TOTAL;
    endproperty

    // sync pulses sit inside blanking
    property sync_in_blank;
        @(posedge i_clk) disable iff (i_rst)
        (i_timing.hsync || i_timing.vsync) |-> i_timing.blank;
    endproperty

    // vsync edges line up with the start of a line
    property vsync_at_line_start;
        @(posedge i_clk) disable iff (i_rst)
        !$stable(i_timing.vsync) |-> (i_timing.x == '0);
    endproperty

    assert property (x_in_range) else $error("pixel counter reached the line total");
    assert property (sync_in_blank) else $error("sync pulse outside blanking");
    assert property (vsync_at_line_start) else $error("vsync changed in mid line");

endmodule

bind video_timing dvi_tx_sva u_sva (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_timing (o_timing)
);

`default_nettype wire

/* sim/tb_dvi_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dvi_tx;

    localparam int H_ACT = 16;
    localparam int H_TOT = 24;
    localparam int HS_BEGIN = 18;
    localparam int HS_LEN = 4;
    localparam int V_ACT = 8;
    localparam int V_TOT = 12;
    localparam int VS_BEGIN = 9;
    localparam int VS_LEN = 2;
    localparam int FRAME_CYCLES = H_TOT * V_TOT;
    localparam int RST_CYCLES = 10;
    localparam int SEED = 60263;
    // test indices into the counters
    localparam int T_RESET = 0;
    localparam int T_CTRL = 1;
    localparam int T_ENC = 2;
    localparam int T_DEC = 3;
    localparam int T_FRAME = 4;
    localparam int T_MIDRST = 5;

    logic       i_clk;
    logic       i_rst;
    logic [9:0] tmds_ch0;
    logic [9:0] tmds_ch1;
    logic [9:0] tmds_ch2;

    int         n_chk [6];
    int         n_err [6];
    // model of the output pipeline that steps once per clock
    int         since_rst;
    int         out_x;
    int         out_y;
    int         disp [3];
    int         frames_done;
    int         rst_test;
    logic       model_on;
    logic       timed_out;
    logic [3:0] ctrl_seen;

    dvi_tx_top u_dut (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .o_tmds_ch0 (tmds_ch0),
        .o_tmds_ch1 (tmds_ch1),
        .o_tmds_ch2 (tmds_ch2)
    );

    always #50 i_clk = ~i_clk;

    function automatic logic [9:0] ctrl_code(input logic [1:0] c);
        case (c)
            2'b00:   return 10'b1101010100;
            2'b01:   return 10'b0010101011;
            2'b10:   return 10'b0101010100;
            default: return 10'b1010101011;
        endcase
    endfunction

    function automatic logic [23:0] expected_pixel(input int x, input int y);
        logic [7:0] g;
        g = 8'(x * 16);
        if (x >= H_ACT || y >= V_ACT) begin
            return 24'h000000;
        end else if (y >= V_ACT / 2) begin
            return {g, g, g};
        end
        case (x / 2)
            0:       return 24'hFFFFFF;
            1:       return 24'hFFFF00;
            2:       return 24'h00FFFF;
            3:       return 24'h00FF00;
            4:       return 24'hFF00FF;
            5:       return 24'hFF0000;
            6:       return 24'h0000FF;
            default: return 24'h000000;
        endcase
    endfunction

    // DVI 1.0 encoder with the running disparity in full units
    function automatic logic [9:0] encode_ref(input logic [7:0] d, input logic [1:0] c,
            input logic blank, input int disp_in, output int disp_out);
        logic [8:0] qm;
        logic       xnor_sel;
        int         n1;
        int         n0;
        int         i;
        xnor_sel = ($countones(d) > 4) || ($countones(d) == 4 && !d[0]);
        qm[0] = d[0];
        for (i = 1; i < 8; i++) begin
            qm[i] = xnor_sel ? ~(qm[i-1] ^ d[i]) : (qm[i-1] ^ d[i]);
        end
        qm[8] = !xnor_sel;
        n1 = $countones(qm[7:0]);
        n0 = 8 - n1;
        if (blank) begin
            disp_out = 0;
            return ctrl_code(c);
        end else if (disp_in == 0 || n1 == n0) begin
            disp_out = qm[8] ? disp_in + n1 - n0 : disp_in + n0 - n1;
            return {~qm[8], qm[8], qm[8] ? qm[7:0] : ~qm[7:0]};
        end else if ((disp_in > 0 && n1 > n0) || (disp_in < 0 && n0 > n1)) begin
            disp_out = disp_in + (qm[8] ? 2 : 0) + n0 - n1;
            return {1'b1, qm[8], ~qm[7:0]};
        end
        disp_out = disp_in - (qm[8] ? 0 : 2) + n1 - n0;
        return {1'b0, qm[8], qm[7:0]};
    endfunction

    function automatic logic [7:0] decode_sym(input logic [9:0] sym);
        logic [7:0] w;
        logic [7:0] d;
        int         i;
        w = sym[9] ? ~sym[7:0] : sym[7:0];
        d[0] = w[0];
        for (i = 1; i < 8; i++) begin
            d[i] = sym[8] ? (w[i] ^ w[i-1]) : ~(w[i] ^ w[i-1]);
        end
        return d;
    endfunction

    function automatic logic [9:0] channel_out(input int ch);
        case (ch)
            0:       return tmds_ch0;
            1:       return tmds_ch1;
            default: return tmds_ch2;
        endcase
    endfunction

    function automatic string chan_name(input int ch);
        return $sformatf("o_tmds_ch%0d", ch);
    endfunction

    task automatic check_val(input int t, input string name, input logic [9:0] exp_v,
            input logic [9:0] act_v);
        n_chk[t]++;
        assert (act_v === exp_v) else begin
            $display("ERR %s expected %h actual %h", name, exp_v, act_v);
            n_err[t]++;
        end
    endtask

    task automatic check_channels(input int t, input logic [9:0] exp_v);
        int ch;
        for (ch = 0; ch < 3; ch++) begin
            check_val(t, chan_name(ch), exp_v, channel_out(ch));
        end
    endtask

    task automatic compare_cycle;
        logic [23:0] rgb;
        logic [9:0]  exp_sym;
        logic [9:0]  act;
        logic [7:0]  pix_byte;
        logic [1:0]  ctrl;
        logic        blank;
        int          ch;
        int          nd;
        blank = (out_x >= H_ACT) || (out_y >= V_ACT);
        ctrl[0] = (out_x >= HS_BEGIN) && (out_x < HS_BEGIN + HS_LEN);
        ctrl[1] = (out_y >= VS_BEGIN) && (out_y < VS_BEGIN + VS_LEN);
        rgb = expected_pixel(out_x, out_y);
        for (ch = 0; ch < 3; ch++) begin
            act = channel_out(ch);
            pix_byte = rgb[ch*8 +: 8];
            if (since_rst < 2) begin
                check_val(rst_test, chan_name(ch), 10'h000, act);
            end else begin
                exp_sym = encode_ref(pix_byte, (ch == 0) ? ctrl : 2'b00, blank, disp[ch], nd);
                disp[ch] = nd;
                if (blank) begin
                    check_val(T_CTRL, chan_name(ch), exp_sym, act);
                    if (ch == 0 && act === exp_sym) begin
                        ctrl_seen[ctrl] = 1'b1;
                    end
                end else begin
                    check_val(T_ENC, chan_name(ch), exp_sym, act);
                    check_val(T_DEC, {chan_name(ch), " decoded"}, {2'b00, pix_byte},
                              {2'b00, decode_sym(act)});
                end
            end
        end
    endtask

    // output position restarts with the DUT reset and trails the counters by two clocks
    always @(posedge i_clk) begin
        if (model_on) begin
            compare_cycle();
        end
        if (i_rst) begin
            since_rst = 0;
            out_x = 0;
            out_y = 0;
            disp = '{0, 0, 0};
            frames_done = 0;
            model_on = 1'b1;
        end else if (since_rst < 2) begin
            since_rst++;
        end else if (out_x < H_TOT - 1) begin
            out_x++;
        end else begin
            out_x = 0;
            out_y = (out_y == V_TOT - 1) ? 0 : out_y + 1;
            if (out_y == 0) begin
                frames_done++;
            end
        end
    end

    task automatic run_reset(input int t);
        int k;
        int nd;
        i_rst <= 1'b1;
        for (k = 0; k < RST_CYCLES; k++) begin
            @(posedge i_clk);
            if (k == RST_CYCLES - 1) begin
                i_rst <= 1'b0;
            end
            @(negedge i_clk);
            check_channels(t, 10'h000);
        end
        // counters back at 0,0 in the first cycle after release
        check_val(t, "timing position", 10'h000, {1'b0, u_dut.timing.y, u_dut.timing.x});
        @(negedge i_clk);
        check_channels(t, 10'h000);
        @(negedge i_clk);
        check_channels(t, encode_ref(8'hFF, 2'b00, 1'b0, 0, nd));
    endtask

    task automatic check_frame_timing;
        int i;
        int blanks;
        int run_len;
        int runs;
        blanks = 0;
        run_len = 0;
        runs = 0;
        for (i = 0; i < FRAME_CYCLES; i++) begin
            if (tmds_ch1 == ctrl_code(2'b00)) begin
                blanks++;
            end
            if (tmds_ch0 == ctrl_code(2'b01) || tmds_ch0 == ctrl_code(2'b11)) begin
                run_len++;
            end else if (run_len > 0) begin
                check_val(T_FRAME, "hsync run length", 10'(HS_LEN), 10'(run_len));
                runs++;
                run_len = 0;
            end
            @(negedge i_clk);
        end
        check_val(T_FRAME, "blank symbol count", 10'(FRAME_CYCLES - H_ACT * V_ACT), 10'(blanks));
        check_val(T_FRAME, "hsync run count", 10'(V_TOT), 10'(runs));
    endtask

    task automatic wait_frames(input int n);
        int cycles;
        cycles = 0;
        while (frames_done < n && cycles < (n + 1) * FRAME_CYCLES) begin
            @(negedge i_clk);
            cycles++;
        end
        if (frames_done < n) begin
            $display("timeout: %0d of %0d frames done after %0d cycles", frames_done, n, cycles);
            timed_out = 1'b1;
        end
    endtask

    task automatic report(input int t, input string name);
        $display("test %s: %0d checks, %0d errors", name, n_chk[t], n_err[t]);
    endtask

    initial begin
        int idle;
        int k;
        int total_chk;
        int total_err;
        i_clk = 1'b0;
        i_rst = 1'b1;
        model_on = 1'b0;
        timed_out = 1'b0;
        ctrl_seen = 4'h0;
        rst_test = T_RESET;
        for (k = 0; k < 6; k++) begin
            n_chk[k] = 0;
            n_err[k] = 0;
        end
        void'($urandom(SEED));

        run_reset(T_RESET);
        report(T_RESET, "reset");
        check_frame_timing();
        report(T_FRAME, "frame timing");
        wait_frames(2);
        n_chk[T_CTRL]++;
        assert (ctrl_seen == 4'hF) else begin
            $display("not all four control codes were seen on channel 0, mask %b", ctrl_seen);
            n_err[T_CTRL]++;
        end
        report(T_CTRL, "control symbols");
        report(T_ENC, "exact encoding");
        report(T_DEC, "decoded colour");

        if (!timed_out) begin
            rst_test = T_MIDRST;
            idle = 20 + int'($urandom_range(300, 0));
            repeat (idle) @(posedge i_clk);
            run_reset(T_MIDRST);
            wait_frames(1);
        end
        report(T_MIDRST, "mid-run reset");

        total_chk = 0;
        total_err = 0;
        for (k = 0; k < 6; k++) begin
            total_chk += n_chk[k];
            total_err += n_err[k];
        end
        $display("summary: %0d checks, %0d errors, timeout %0d", total_chk, total_err, timed_out);
        if (timed_out || total_err > 0) begin
            $display("STATUS: FAIL");
        end else begin
            $display("STATUS: PASS");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
common/video_pkg.sv
source/video_timing.sv
source/color_bar_gen.sv
tmds/tmds_encoder.sv
source/dvi_tx_top.sv
sim/dvi_tx_sva.sv
sim/tb_dvi_tx.sv

/* Makefile */
TOP := tb_dvi_tx

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "STATUS: FAIL" sim.log; then exit 1; fi
	@grep -q "STATUS: PASS" sim.log

lint:
	verilator --lint-only -Wall --timing --assert -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
